// ==== vlog.f ====
hw/capture_pkg.sv
hw/host_bus_pkg.sv
hw/sample_wr_if.sv
hw/adc_sync.sv
hw/capture_ctrl.sv
hw/pingpong_ram.sv
hw/host_bus_slave.sv
hw/adc_capture_top.sv
testbench/capture_monitor.sv
testbench/tb_adc_capture.sv

// ==== Bender.yml ====
package:
  name: adc_capture

sources:
  - hw/capture_pkg.sv
  - hw/host_bus_pkg.sv
  - hw/sample_wr_if.sv
  - hw/adc_sync.sv
  - hw/capture_ctrl.sv
  - hw/pingpong_ram.sv
  - hw/host_bus_slave.sv
  - hw/adc_capture_top.sv
  - target: simulation
    files:
      - testbench/capture_monitor.sv
      - testbench/tb_adc_capture.sv

// ==== testbench/capture_vectors.txt ====
// capture vectors, one 16-bit hex word per entry
// words 0-15 set A samples, words 16-31 set B samples, word 32 samples before abort
// words 33-39 expected status: reset, A done, locked, unlocked, B done, fault, recovered

// set A
0A5 1F3 2C8 37E 4B1 5D9 6E2 7FF
800 91C A47 B6D C3A D58 E0F FFF

// set B
F5A E0C D37 C92 B4E A61 9D0 8B3
7C4 61F 52A 4E8 3B7 206 19D 001

// samples before abort
0005

// expected status words
0000 0001 0001 0000
0001 0002 0000

// ==== testbench/tb_adc_capture.sv ====
module tb_adc_capture;
    import capture_pkg::*;
    import host_bus_pkg::*;

    localparam int DEPTH     = 16;
    localparam int AW        = $clog2(DEPTH);
    localparam int SET_A     = 0;
    localparam int SET_B     = 16;
    localparam int ABORT_IDX = 32;
    localparam int STAT_IDX  = 33;   // first expected status word
    localparam int POLLS     = 60;

    logic      clk;
    logic      rst_n;
    logic      adc_clk;
    sample_t   adc_data;
    logic      stable;
    logic      trigger;
    logic      bus_en;
    logic      bus_dir;
    bus_word_t bus_din;
    bus_word_t bus_dout;
    logic      exp_valid;
    bus_word_t exp_data;

    logic [15:0] vec_mem [0:39];
    sample_t     cur_set [0:DEPTH-1];   // words the ADC model plays out
    int          adc_falls;
    int          adc_base;
    logic [7:0]  lfsr;
    bus_word_t   last_dout;

    adc_capture_top #(.BUF_DEPTH(DEPTH)) dut_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .adc_clk  (adc_clk),
        .adc_data (adc_data),
        .stable   (stable),
        .trigger  (trigger),
        .bus_en   (bus_en),
        .bus_dir  (bus_dir),
        .bus_din  (bus_din),
        .bus_dout (bus_dout)
    );

    capture_monitor mon_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .exp_valid (exp_valid),
        .exp_data  (exp_data),
        .bus_dout  (bus_dout)
    );

    always #50 clk = ~clk;

    // offset keeps adc_clk edges away from clk edges
    initial begin
        adc_clk = 1'b0;
        #25;
        forever #350 adc_clk = ~adc_clk;
    end

    // ADC model, next word on the falling edge
    always @(negedge adc_clk) begin
        if (adc_falls - adc_base < DEPTH) begin
            adc_data <= cur_set[adc_falls - adc_base];
        end else begin
            adc_data <= cur_set[DEPTH-1];
        end
        adc_falls <= adc_falls + 1;
    end

    function automatic logic [7:0] lfsr_next(input logic [7:0] s);
        return {s[6:0], s[7] ^ s[5] ^ s[4] ^ s[3]};   // x^8+x^6+x^5+x^4+1
    endfunction

    task automatic pick_addr(output logic [AW-1:0] a);
        for (int i = 0; i < AW; i++) begin
            lfsr = lfsr_next(lfsr);   // one step per address bit
            a[i] = lfsr[0];
        end
    endtask

    task automatic bus_read(input bus_word_t addr, input logic check, input bus_word_t exp);
        bus_din = addr;
        bus_dir = 1'b1;
        @(negedge clk);
        bus_en = 1'b1;
        repeat (8) @(negedge clk);
        last_dout = bus_dout;
        bus_en    = 1'b0;
        exp_valid = check;
        exp_data  = exp;
        @(negedge clk);
        exp_valid = 1'b0;
        repeat (7) @(negedge clk);
    endtask

    task automatic bus_write(input bus_word_t addr, input bus_word_t data);
        bus_din = addr;
        bus_dir = 1'b0;
        @(negedge clk);
        bus_en = 1'b1;
        repeat (4) @(negedge clk);
        bus_din = data;   // held through the low phase
        repeat (4) @(negedge clk);
        bus_en = 1'b0;
        repeat (8) @(negedge clk);
    endtask

    task automatic wait_status(input bus_word_t mask, input bus_word_t want, input string what);
        int polls = 0;
        bus_read(STATUS_ADDR, 1'b0, '0);
        while ((last_dout & mask) != want && polls < POLLS) begin
            bus_read(STATUS_ADDR, 1'b0, '0);
            polls++;
        end
        if ((last_dout & mask) != want) begin
            mon_i.report_timeout(what);
        end
    endtask

    task automatic wait_adc_falls(input int n, input string what);
        int base   = adc_falls;
        int cycles = 0;
        while (adc_falls - base < n && cycles < 8 * n + 16) begin
            @(negedge clk);
            cycles++;
        end
        if (adc_falls - base < n) begin
            mon_i.report_timeout(what);
        end
    endtask

    // trigger right after the fall that puts out word 0
    task automatic start_capture(input int set_idx);
        for (int i = 0; i < DEPTH; i++) begin
            cur_set[i] = vec_mem[set_idx + i][11:0];
        end
        adc_base = adc_falls;
        wait_adc_falls(1, "the ADC frame start");
        trigger = 1'b1;
        repeat (4) @(negedge clk);
        trigger = 1'b0;
    endtask

    task automatic check_samples(input int set_idx, input int count);
        logic [AW-1:0] a;
        repeat (count) begin
            pick_addr(a);
            bus_read(bus_word_t'(a), 1'b1, {4'h0, vec_mem[set_idx + a][11:0]});
        end
    endtask

    initial begin
        clk       = 1'b0;
        rst_n     = 1'b0;
        adc_data  = '0;
        stable    = 1'b1;
        trigger   = 1'b0;
        bus_en    = 1'b0;
        bus_dir   = 1'b0;
        bus_din   = '0;
        exp_valid = 1'b0;
        exp_data  = '0;
        adc_falls = 0;
        adc_base  = 0;
        lfsr      = 8'd72;
        last_dout = '0;
        for (int i = 0; i < DEPTH; i++) begin
            cur_set[i] = '0;
        end
        $readmemh("testbench/capture_vectors.txt", vec_mem);
        repeat (5) @(negedge clk);
        rst_n = 1'b1;
        repeat (4) @(negedge clk);

        bus_read(STATUS_ADDR, 1'b1, vec_mem[STAT_IDX]);

        start_capture(SET_A);
        wait_status(16'h0001, 16'h0001, "capture of set A to finish");
        bus_read(STATUS_ADDR, 1'b1, vec_mem[STAT_IDX + 1]);
        check_samples(SET_A, DEPTH);

        // locked, so set B must not land
        bus_write(STATUS_ADDR, 16'h0001);
        start_capture(SET_B);
        wait_adc_falls(DEPTH + 4, "the locked trigger window");
        check_samples(SET_A, 4);
        bus_read(STATUS_ADDR, 1'b1, vec_mem[STAT_IDX + 2]);
        bus_write(STATUS_ADDR, 16'h0000);
        bus_read(STATUS_ADDR, 1'b1, vec_mem[STAT_IDX + 3]);

        start_capture(SET_B);
        wait_status(16'h0001, 16'h0001, "capture of set B to finish");
        bus_read(STATUS_ADDR, 1'b1, vec_mem[STAT_IDX + 4]);
        check_samples(SET_B, DEPTH);

        bus_write(STATUS_ADDR, 16'h0001);   // lock and release clears ready
        bus_write(STATUS_ADDR, 16'h0000);
        start_capture(SET_A);
        wait_adc_falls(vec_mem[ABORT_IDX], "samples before the abort");
        stable = 1'b0;
        wait_status(16'h0002, 16'h0002, "the fault flag");
        bus_read(STATUS_ADDR, 1'b1, vec_mem[STAT_IDX + 5]);
        check_samples(SET_B, 4);
        stable = 1'b1;
        wait_status(16'h0002, 16'h0000, "the fault flag to clear");
        bus_read(STATUS_ADDR, 1'b1, vec_mem[STAT_IDX + 6]);

        bus_read(16'h0010, 1'b1, 16'hFFFF);
        bus_read(16'h3FFF, 1'b1, 16'hFFFF);
        bus_read(16'h4001, 1'b1, 16'hFFFF);
        bus_read(16'hFFFF, 1'b1, 16'hFFFF);

        mon_i.print_counts();
        if (mon_i.error_count() == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// ==== testbench/capture_monitor.sv ====
module capture_monitor (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    exp_valid,
    input  host_bus_pkg::bus_word_t exp_data,
    input  host_bus_pkg::bus_word_t bus_dout
);
    int check_cnt    = 0;
    int mismatch_cnt = 0;
    int timeout_cnt  = 0;

    // bus_dout is settled long before exp_valid arrives
    always @(posedge clk) begin
        if (rst_n && exp_valid) begin
            check_cnt++;
            if (bus_dout !== exp_data) begin
                mismatch_cnt++;
                $display("[ERROR] bus_dout exp %h got %h", exp_data, bus_dout);
            end
        end
    end

    task automatic report_timeout(input string what);
        timeout_cnt++;
        $display("timed out while waiting for %s", what);
    endtask

    function automatic int error_count();
        return mismatch_cnt + timeout_cnt;
    endfunction

    task automatic print_counts();
        $display("checks %0d, mismatches %0d, timeouts %0d",
                 check_cnt, mismatch_cnt, timeout_cnt);
    endtask

endmodule

// ==== hw/adc_capture_top.sv ====
module adc_capture_top #(
    parameter int BUF_DEPTH = 1024   // power of two, at most 16384
) (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic                             adc_clk,
    input  logic [capture_pkg::SAMPLE_W-1:0] adc_data,
    input  logic                             stable,
    input  logic                             trigger,
    input  logic                             bus_en,
    input  logic                             bus_dir,
    input  host_bus_pkg::bus_word_t          bus_din,
    output host_bus_pkg::bus_word_t          bus_dout
);
    import capture_pkg::*;

    logic                         sample_stb;
    sample_t                      sample;
    logic                         stable_s;
    logic                         trig_rise;
    logic                         bank_done;
    logic                         fault;
    logic                         lock;
    logic [$clog2(BUF_DEPTH)-1:0] rd_addr;
    sample_t                      rd_data;

    sample_wr_if #(.BUF_DEPTH(BUF_DEPTH)) wr_if ();

    adc_sync sync_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .adc_clk    (adc_clk),
        .adc_data   (adc_data),
        .stable     (stable),
        .trigger    (trigger),
        .sample_stb (sample_stb),
        .sample     (sample),
        .stable_s   (stable_s),
        .trig_rise  (trig_rise)
    );

    capture_ctrl #(.BUF_DEPTH(BUF_DEPTH)) ctrl_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .sample_stb (sample_stb),
        .sample     (sample),
        .stable_s   (stable_s),
        .trig_rise  (trig_rise),
        .lock       (lock),
        .wr         (wr_if.ctrl),
        .bank_done  (bank_done),
        .fault      (fault)
    );

    pingpong_ram #(.BUF_DEPTH(BUF_DEPTH)) ram_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .wr      (wr_if.ram),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

    host_bus_slave #(.BUF_DEPTH(BUF_DEPTH)) host_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .bus_en    (bus_en),
        .bus_dir   (bus_dir),
        .bus_din   (bus_din),
        .bank_done (bank_done),
        .fault     (fault),
        .rd_data   (rd_data),
        .bus_dout  (bus_dout),
        .lock      (lock),
        .rd_addr   (rd_addr)
    );

endmodule

// ==== hw/host_bus_slave.sv ====
module host_bus_slave #(
    parameter int BUF_DEPTH = 1024
) (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         bus_en,
    input  logic                         bus_dir,    // 1 = host reads
    input  host_bus_pkg::bus_word_t      bus_din,
    input  logic                         bank_done,
    input  logic                         fault,
    input  capture_pkg::sample_t         rd_data,
    output host_bus_pkg::bus_word_t      bus_dout,
    output logic                         lock,
    output logic [$clog2(BUF_DEPTH)-1:0] rd_addr
);
    import host_bus_pkg::*;

    localparam int AW = $clog2(BUF_DEPTH);

    bus_state_t state;
    logic [1:0] en_sync;
    logic       en_prev;
    logic       en_rise;
    logic       en_fall;
    bus_word_t  addr_q;
    logic       sel_sample;
    logic       sel_status;
    logic       read_go;
    logic       ready;
    logic       unlock;
    bus_word_t  rd_word;

    assign en_rise = en_sync[1] & ~en_prev;
    assign en_fall = ~en_sync[1] & en_prev;
    assign rd_addr = addr_q[AW-1:0];   // RAM read runs during decode

    // lock going 1 -> 0 releases the bank
    assign unlock = (state == BUS_WRITE) && en_fall && (addr_q == STATUS_ADDR)
                    && lock && !bus_din[0];

    always_comb begin
        if (sel_sample) begin
            rd_word = BUS_W'(rd_data);   // zero-extended
        end else if (sel_status) begin
            rd_word = {{(BUS_W - 2){1'b0}}, fault, ready};
        end else begin
            rd_word = UNMAPPED_DATA;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= BUS_IDLE;
            en_sync  <= '0;
            en_prev  <= 1'b0;
            read_go  <= 1'b0;
            lock     <= 1'b0;
            bus_dout <= '0;
        end else begin
            en_sync <= {en_sync[0], bus_en};
            en_prev <= en_sync[1];
            read_go <= 1'b0;
            case (state)
                BUS_IDLE: begin
                    if (en_rise) begin
                        state <= BUS_DECODE;
                    end
                end
                BUS_DECODE: begin
                    state   <= bus_dir ? BUS_READ : BUS_WRITE;
                    read_go <= bus_dir;
                end
                BUS_READ: begin
                    if (read_go) begin
                        bus_dout <= rd_word;   // held until the next read
                    end
                    if (en_fall) begin
                        state <= BUS_IDLE;
                    end
                end
                BUS_WRITE: begin
                    // data word is still on bus_din after the synced fall
                    if (en_fall) begin
                        if (addr_q == STATUS_ADDR) begin
                            lock <= bus_din[0];
                        end
                        state <= BUS_IDLE;
                    end
                end
                default: state <= BUS_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == BUS_IDLE && en_rise) begin
            addr_q <= bus_din;
        end
        if (state == BUS_DECODE) begin
            sel_sample <= (addr_q < BUF_DEPTH);
            sel_status <= (addr_q == STATUS_ADDR);
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ready <= 1'b0;
        end else if (bank_done) begin
            ready <= 1'b1;   // new bank wins over a release
        end else if (unlock) begin
            ready <= 1'b0;
        end
    end

    a_dout_in_cycle: assert property (@(posedge clk) disable iff (!rst_n)
        !$stable(bus_dout) |-> $past(en_sync[1]));

endmodule

// ==== hw/pingpong_ram.sv ====
module pingpong_ram #(
    parameter int BUF_DEPTH = 1024
) (
    input  logic                         clk,
    input  logic                         rst_n,
    sample_wr_if.ram                     wr,
    input  logic [$clog2(BUF_DEPTH)-1:0] rd_addr,
    output capture_pkg::sample_t         rd_data
);
    import capture_pkg::*;

    sample_t bank0_mem [BUF_DEPTH];
    sample_t bank1_mem [BUF_DEPTH];

    always_ff @(posedge clk) begin
        if (wr.we) begin
            if (wr.bank) begin
                bank1_mem[wr.addr] <= wr.data;
            end else begin
                bank0_mem[wr.addr] <= wr.data;
            end
        end
    end

    // host always sees the bank not being filled
    always_ff @(posedge clk) begin
        if (wr.bank) begin
            rd_data <= bank0_mem[rd_addr];
        end else begin
            rd_data <= bank1_mem[rd_addr];
        end
    end

    // bank never flips under a write
    a_bank_steady: assert property (@(posedge clk) disable iff (!rst_n)
        !$stable(wr.bank) |-> !wr.we);

endmodule

// ==== hw/capture_ctrl.sv ====
module capture_ctrl #(
    parameter int BUF_DEPTH = 1024
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 sample_stb,
    input  capture_pkg::sample_t sample,
    input  logic                 stable_s,
    input  logic                 trig_rise,
    input  logic                 lock,
    sample_wr_if.ctrl            wr,
    output logic                 bank_done,
    output logic                 fault
);
    import capture_pkg::*;

    localparam int AW = $clog2(BUF_DEPTH);

    cap_state_t    state;
    logic [AW-1:0] wr_ptr;
    logic          bank;
    logic          last_wr;

    // write goes straight out so it lands before the bank flips
    assign wr.we   = (state == CAP_SAMPLING) && stable_s && sample_stb;
    assign wr.addr = wr_ptr;
    assign wr.data = sample;
    assign wr.bank = bank;

    assign last_wr = wr.we && (wr_ptr == AW'(BUF_DEPTH - 1));
    assign fault   = (state == CAP_FAULT);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= CAP_IDLE;
            wr_ptr    <= '0;
            bank      <= 1'b0;
            bank_done <= 1'b0;
        end else begin
            bank_done <= last_wr;
            case (state)
                CAP_IDLE: begin
                    if (trig_rise && stable_s && !lock) begin
                        state  <= CAP_SAMPLING;
                        wr_ptr <= '0;
                    end
                end
                CAP_SAMPLING: begin
                    if (!stable_s) begin
                        state <= CAP_FAULT;     // partial bank dropped, bank kept
                    end else if (last_wr) begin
                        state <= CAP_IDLE;
                        bank  <= ~bank;         // full bank handed to the host side
                    end else if (wr.we) begin
                        wr_ptr <= wr_ptr + 1'b1;
                    end
                end
                CAP_FAULT: begin
                    if (stable_s) begin
                        state <= CAP_IDLE;
                    end
                end
                default: state <= CAP_IDLE;
            endcase
        end
    end

    // one write per ADC sample strobe
    a_we_single: assert property (@(posedge clk) disable iff (!rst_n)
        wr.we |=> !wr.we);

    a_done_single: assert property (@(posedge clk) disable iff (!rst_n)
        bank_done |=> !bank_done);

endmodule

// ==== hw/adc_sync.sv ====
module adc_sync (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic                             adc_clk,
    input  logic [capture_pkg::SAMPLE_W-1:0] adc_data,
    input  logic                             stable,
    input  logic                             trigger,
    output logic                             sample_stb,
    output capture_pkg::sample_t             sample,
    output logic                             stable_s,
    output logic                             trig_rise
);

    logic [2:0] adc_clk_q;
    logic [2:0] stable_q;
    logic [2:0] trigger_q;
    logic       adc_edge;
    logic       trig_edge;

    // edges taken from the 2nd and 3rd stage
    assign adc_edge  = adc_clk_q[1] & ~adc_clk_q[2];
    assign trig_edge = trigger_q[1] & ~trigger_q[2];
    assign stable_s  = stable_q[2];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            adc_clk_q  <= '0;
            stable_q   <= '0;
            trigger_q  <= '0;
            sample_stb <= 1'b0;
            trig_rise  <= 1'b0;
        end else begin
            adc_clk_q  <= {adc_clk_q[1:0], adc_clk};
            stable_q   <= {stable_q[1:0], stable};
            trigger_q  <= {trigger_q[1:0], trigger};
            sample_stb <= adc_edge;   // same edge that loads sample
            trig_rise  <= trig_edge;
        end
    end

    // adc_data is steady here, it only moves on the adc_clk fall
    always_ff @(posedge clk) begin
        if (adc_edge) begin
            sample <= adc_data;
        end
    end

endmodule

// ==== hw/sample_wr_if.sv ====
interface sample_wr_if #(
    parameter int BUF_DEPTH = 1024
);
    import capture_pkg::*;

    logic                         we;    // one cycle per sample
    logic                         bank;  // bank being filled
    logic [$clog2(BUF_DEPTH)-1:0] addr;
    sample_t                      data;

    modport ctrl (
        output we,
        output bank,
        output addr,
        output data
    );

    modport ram (
        input we,
        input bank,
        input addr,
        input data
    );

endinterface

// ==== hw/host_bus_pkg.sv ====
package host_bus_pkg;

    localparam int BUS_W = 16;

    typedef logic [BUS_W-1:0] bus_word_t;

    // status and lock register, above every sample address
    localparam bus_word_t STATUS_ADDR   = 16'h4000;
    localparam bus_word_t UNMAPPED_DATA = '1;

    // bus sequencer states
    typedef enum logic [1:0] {
        BUS_IDLE,
        BUS_DECODE,
        BUS_WRITE,       // host writes, slave takes bus_din
        BUS_READ         // host reads, slave drives bus_dout
    } bus_state_t;

endpackage

// ==== hw/capture_pkg.sv ====
package capture_pkg;

    // ADC sample width
    localparam int SAMPLE_W = 12;

    typedef logic [SAMPLE_W-1:0] sample_t;

    // capture FSM states
    typedef enum logic [1:0] {
        CAP_IDLE,
        CAP_SAMPLING,
        CAP_FAULT        // stable dropped mid capture
    } cap_state_t;

endpackage
